// File: common/eth_pkg.sv
// ethernet framing and crc constants, imported by the receive logic and the testbench
`default_nettype none

package eth_pkg;

    // preamble and start frame delimiter
    localparam logic [7:0] eth_preamble = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hD5;

    // crc-32, bit-reversed form of 0x04C11DB7
    localparam logic [31:0] eth_crc_poly = 32'hEDB88320;

    // state left over after a frame with a good fcs
    localparam logic [31:0] eth_crc_residue = ~32'h2144DF1C;

    localparam logic [7:0] eth_bcast_byte = 8'hFF;

    // 802.1q tag protocol identifier
    localparam logic [7:0] eth_vlan_tpid_hi = 8'h81;
    localparam logic [7:0] eth_vlan_tpid_lo = 8'h00;

    // ethertype position in the header
    localparam logic [3:0] eth_tpid_offset = 4'd12;

    // bytes in a mac address
    localparam logic [3:0] eth_mac_len = 4'd6;

endpackage

`default_nettype wire

// File: common/rx_pkg.sv
// receiver types, fsm states and pipeline sizes, imported wherever the receiver is used
`default_nettype none

package rx_pkg;

    // one gmii byte
    typedef logic [7:0] gmii_byte_t;

    // frame length or length limit
    typedef logic [15:0] frame_len_t;

    // crc-32 state
    typedef logic [31:0] crc_t;

    // index into the first header bytes
    typedef logic [3:0] hdr_ptr_t;

    typedef enum logic [1:0] {
        state_idle,
        state_pipe,
        state_payload
    } rx_state_t;

    // delay stages, enough to hold back the four fcs bytes
    localparam int pipe_depth = 5;

    // usual limit for an untagged frame
    localparam frame_len_t default_max_len = 16'd1518;

endpackage

`default_nettype wire

// File: common/rx_tap_if.sv
// taps of the gmii delay line, driven by the input pipeline and read by the frame controller
`timescale 1ns/10ps
`default_nettype none

interface rx_tap_if import rx_pkg::*; ();

    // raw inputs of the current cycle
    gmii_byte_t rxd_in;
    logic       dv_in;
    logic       er_in;

    // first register stage
    gmii_byte_t rxd_d0;
    logic       dv_d0;
    logic       er_d0;

    // last register stage
    gmii_byte_t rxd_d4;
    logic       dv_d4;
    logic       er_d4;

    modport pipe (output rxd_in, dv_in, er_in, rxd_d0, dv_d0, er_d0, rxd_d4, dv_d4, er_d4);

    modport ctrl (input rxd_in, dv_in, er_in, rxd_d0, dv_d0, er_d0, rxd_d4, dv_d4, er_d4);

endinterface

`default_nettype wire

// File: hw/gmii_rx_pipe.sv
// gmii input registers and delay line, publishes the raw inputs and two stages as taps
`timescale 1ns/10ps
`default_nettype none

module gmii_rx_pipe import rx_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_crc,
    input  wire gmii_byte_t gmii_rxd,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    rx_tap_if.pipe          taps
);

    gmii_byte_t            rxd_sr [pipe_depth];
    logic [pipe_depth-1:0] dv_sr;
    logic [pipe_depth-1:0] er_sr;

    assign taps.rxd_in = gmii_rxd;
    assign taps.dv_in  = gmii_rx_dv;
    assign taps.er_in  = gmii_rx_er;

    always_ff @(posedge clk) begin
        rxd_sr[0] <= taps.rxd_in;
        for (int i = 1; i < pipe_depth; i++) begin
            rxd_sr[i] <= rxd_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            dv_sr <= '0;
            er_sr <= '0;
        end else begin
            dv_sr <= {dv_sr[pipe_depth-2:0], taps.dv_in};
            er_sr <= {er_sr[pipe_depth-2:0], taps.er_in};
        end
    end

    assign taps.rxd_d0 = rxd_sr[0];
    assign taps.dv_d0  = dv_sr[0];
    assign taps.er_d0  = er_sr[0];
    assign taps.rxd_d4 = rxd_sr[pipe_depth-1];
    assign taps.dv_d4  = dv_sr[pipe_depth-1];
    assign taps.er_d4  = er_sr[pipe_depth-1];

    // an error flag only arrives together with valid
    assert property (@(posedge clk) disable iff (reset_crc)
        taps.er_d0 |-> taps.dv_d0);

endmodule

`default_nettype wire

// File: hw/fcs_check.sv
// byte-wide ethernet crc-32 accumulator, flags a good fcs on the last byte of a frame
`timescale 1ns/10ps
`default_nettype none

module fcs_check import eth_pkg::*; import rx_pkg::*; (
    input  wire logic       clk,
    input  wire gmii_byte_t data,
    input  wire logic       crc_init,
    input  wire logic       crc_update,
    output logic            crc_ok
);

    crc_t crc_state;
    crc_t crc_next;

    // lsb first, one shift per data bit
    function automatic crc_t crc_byte(input crc_t state, input gmii_byte_t din);
        crc_t c;
        c = state;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ din[i]) begin
                c = (c >> 1) ^ eth_crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_state, data);

    // includes the byte now at the tap
    assign crc_ok = (crc_next == eth_crc_residue);

    always_ff @(posedge clk) begin
        if (crc_init) begin
            crc_state <= '1;
        end else if (crc_update) begin
            crc_state <= crc_next;
        end
    end

    // updates only ever follow a restart
    assert property (@(posedge clk) crc_update |-> !$isunknown(crc_state));

endmodule

`default_nettype wire

// File: hw/rx_frame_ctrl/rx_frame_ctrl.sv
// receive fsm, checks preamble, classifies the header and emits the byte stream and status
`timescale 1ns/10ps
`default_nettype none

module rx_frame_ctrl import eth_pkg::*; import rx_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_crc,
    rx_tap_if.ctrl          taps,
    input  wire logic       crc_ok,
    output logic            crc_init,
    output logic            crc_update,
    input  wire logic       cfg_rx_enable,
    input  wire frame_len_t cfg_rx_max_pkt_len,
    output gmii_byte_t      rx_tdata,
    output logic            rx_tvalid,
    output logic            rx_tlast,
    output logic            rx_tuser,
    output frame_len_t      stat_rx_pkt_len,
    output logic            stat_rx_pkt_good,
    output logic            stat_rx_pkt_bad,
    output logic            stat_rx_pkt_ucast,
    output logic            stat_rx_pkt_mcast,
    output logic            stat_rx_pkt_bcast,
    output logic            stat_rx_pkt_vlan,
    output logic            stat_rx_err_bad_fcs,
    output logic            stat_rx_err_oversize,
    output logic            stat_rx_err_bad_block,
    output logic            stat_rx_err_preamble
);

    rx_state_t  state_reg, state_next;
    logic       frame_error_reg, frame_error_next;
    logic       in_pre_reg, in_pre_next;
    logic       pre_ok_reg, pre_ok_next;
    hdr_ptr_t   hdr_ptr_reg, hdr_ptr_next;
    logic       is_mcast_reg, is_mcast_next;
    logic       is_bcast_reg, is_bcast_next;
    logic       is_vlan_reg, is_vlan_next;
    frame_len_t frame_len_reg, frame_len_next;
    frame_len_t len_lim_reg, len_lim_next;

    gmii_byte_t tdata_next;
    logic       tvalid_next;
    logic       tlast_next;
    logic       tuser_next;
    frame_len_t pkt_len_next;
    logic       good_next;
    logic       bad_next;
    logic       ucast_next;
    logic       mcast_next;
    logic       bcast_next;
    logic       vlan_next;
    logic       bad_fcs_next;
    logic       oversize_next;
    logic       bad_block_next;
    logic       preamble_next;

    always_comb begin
        state_next = state_reg;
        crc_init = 1'b0;
        crc_update = 1'b0;

        frame_error_next = frame_error_reg;
        in_pre_next = in_pre_reg;
        pre_ok_next = pre_ok_reg;
        hdr_ptr_next = hdr_ptr_reg;
        is_mcast_next = is_mcast_reg;
        is_bcast_next = is_bcast_reg;
        is_vlan_next = is_vlan_reg;
        frame_len_next = frame_len_reg;
        len_lim_next = len_lim_reg;

        tdata_next = taps.rxd_d4;
        tvalid_next = 1'b0;
        tlast_next = 1'b0;
        tuser_next = 1'b0;
        pkt_len_next = '0;
        good_next = 1'b0;
        bad_next = 1'b0;
        ucast_next = 1'b0;
        mcast_next = 1'b0;
        bcast_next = 1'b0;
        vlan_next = 1'b0;
        bad_fcs_next = 1'b0;
        oversize_next = 1'b0;
        bad_block_next = 1'b0;
        preamble_next = 1'b0;

        // saturating counters
        if (frame_len_reg != '1) begin
            frame_len_next = frame_len_reg + 16'd1;
        end
        if (len_lim_reg != '0) begin
            len_lim_next = len_lim_reg - 16'd1;
        end
        if (hdr_ptr_reg != '1) begin
            hdr_ptr_next = hdr_ptr_reg + 4'd1;
        end

        // destination class and tag, taken at the last tap
        if (hdr_ptr_reg == '0) begin
            is_mcast_next = taps.rxd_d4[0];
            is_bcast_next = (taps.rxd_d4 == eth_bcast_byte);
        end else if (hdr_ptr_reg < eth_mac_len) begin
            is_bcast_next = is_bcast_reg && (taps.rxd_d4 == eth_bcast_byte);
        end else if (hdr_ptr_reg == eth_tpid_offset) begin
            is_vlan_next = (taps.rxd_d4 == eth_vlan_tpid_hi);
        end else if (hdr_ptr_reg == eth_tpid_offset + 4'd1) begin
            is_vlan_next = is_vlan_reg && (taps.rxd_d4 == eth_vlan_tpid_lo);
        end

        case (state_reg)
            state_idle: begin
                crc_init = 1'b1;
                frame_error_next = 1'b0;
                frame_len_next = 16'd1;
                len_lim_next = cfg_rx_max_pkt_len;
                hdr_ptr_next = '0;
                is_mcast_next = 1'b0;
                is_bcast_next = 1'b0;
                is_vlan_next = 1'b0;

                if (taps.dv_d0) begin
                    if (taps.er_d0) begin
                        in_pre_next = 1'b0;
                        pre_ok_next = 1'b0;
                    end else if (taps.rxd_d0 == eth_sfd) begin
                        in_pre_next = 1'b0;
                        if (in_pre_reg && cfg_rx_enable) begin
                            state_next = state_pipe;
                            // first byte after the sfd is already at the input
                            frame_error_next = taps.dv_in && taps.er_in;
                        end
                    end else if (taps.rxd_d0 != eth_preamble) begin
                        pre_ok_next = 1'b0;
                    end
                end else begin
                    in_pre_next = 1'b1;
                    pre_ok_next = 1'b1;
                end
            end
            state_pipe: begin
                crc_update = 1'b1;
                hdr_ptr_next = '0;
                is_mcast_next = 1'b0;
                is_bcast_next = 1'b0;
                is_vlan_next = 1'b0;
                if (taps.dv_in && taps.er_in) begin
                    frame_error_next = 1'b1;
                end
                // sfd has reached the end of the delay line
                if (taps.dv_d4 && !taps.er_d4 && taps.rxd_d4 == eth_sfd) begin
                    state_next = state_payload;
                end
            end
            state_payload: begin
                crc_update = 1'b1;
                tvalid_next = 1'b1;
                if (taps.dv_in && taps.er_in) begin
                    frame_error_next = 1'b1;
                end
                if (!taps.dv_in) begin
                    // fcs is in the delay line now, close the frame
                    crc_init = 1'b1;
                    state_next = state_idle;
                    tlast_next = 1'b1;
                    pkt_len_next = frame_len_reg;
                    ucast_next = !is_mcast_reg;
                    mcast_next = is_mcast_reg && !is_bcast_reg;
                    bcast_next = is_bcast_reg;
                    vlan_next = is_vlan_reg;
                    oversize_next = (len_lim_reg == '0);
                    bad_block_next = frame_error_reg;
                    preamble_next = !pre_ok_reg;
                    bad_fcs_next = !frame_error_reg && !crc_ok;
                    if (frame_error_reg || !crc_ok || len_lim_reg == '0) begin
                        tuser_next = 1'b1;
                        bad_next = 1'b1;
                    end else begin
                        good_next = 1'b1;
                    end
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg <= state_idle;
            frame_error_reg <= 1'b0;
            in_pre_reg <= 1'b0;
            pre_ok_reg <= 1'b0;
            rx_tvalid <= 1'b0;
            rx_tlast <= 1'b0;
            rx_tuser <= 1'b0;
            stat_rx_pkt_len <= '0;
            stat_rx_pkt_good <= 1'b0;
            stat_rx_pkt_bad <= 1'b0;
            stat_rx_pkt_ucast <= 1'b0;
            stat_rx_pkt_mcast <= 1'b0;
            stat_rx_pkt_bcast <= 1'b0;
            stat_rx_pkt_vlan <= 1'b0;
            stat_rx_err_bad_fcs <= 1'b0;
            stat_rx_err_oversize <= 1'b0;
            stat_rx_err_bad_block <= 1'b0;
            stat_rx_err_preamble <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_error_reg <= frame_error_next;
            in_pre_reg <= in_pre_next;
            pre_ok_reg <= pre_ok_next;
            rx_tvalid <= tvalid_next;
            rx_tlast <= tlast_next;
            rx_tuser <= tuser_next;
            stat_rx_pkt_len <= pkt_len_next;
            stat_rx_pkt_good <= good_next;
            stat_rx_pkt_bad <= bad_next;
            stat_rx_pkt_ucast <= ucast_next;
            stat_rx_pkt_mcast <= mcast_next;
            stat_rx_pkt_bcast <= bcast_next;
            stat_rx_pkt_vlan <= vlan_next;
            stat_rx_err_bad_fcs <= bad_fcs_next;
            stat_rx_err_oversize <= oversize_next;
            stat_rx_err_bad_block <= bad_block_next;
            stat_rx_err_preamble <= preamble_next;
        end
    end

    always_ff @(posedge clk) begin
        hdr_ptr_reg <= hdr_ptr_next;
        is_mcast_reg <= is_mcast_next;
        is_bcast_reg <= is_bcast_next;
        is_vlan_reg <= is_vlan_next;
        frame_len_reg <= frame_len_next;
        len_lim_reg <= len_lim_next;
        rx_tdata <= tdata_next;
    end

    assert property (@(posedge clk) disable iff (reset_crc) rx_tlast |-> rx_tvalid);

    assert property (@(posedge clk) disable iff (reset_crc)
        !(stat_rx_pkt_good && stat_rx_pkt_bad));

endmodule

`default_nettype wire

// File: hw/gmii_rx_top.sv
// gmii frame receiver top, 8-bit gmii in, byte stream and per-frame status pulses out
`timescale 1ns/10ps
`default_nettype none

// cfg_rx_max_pkt_len is normally default_max_len (1518) for untagged frames
module gmii_rx_top import rx_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_crc,
    input  wire gmii_byte_t gmii_rxd,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    input  wire logic       cfg_rx_enable,
    input  wire frame_len_t cfg_rx_max_pkt_len,
    output wire gmii_byte_t rx_tdata,
    output wire logic       rx_tvalid,
    output wire logic       rx_tlast,
    output wire logic       rx_tuser,
    output wire frame_len_t stat_rx_pkt_len,
    output wire logic       stat_rx_pkt_good,
    output wire logic       stat_rx_pkt_bad,
    output wire logic       stat_rx_pkt_ucast,
    output wire logic       stat_rx_pkt_mcast,
    output wire logic       stat_rx_pkt_bcast,
    output wire logic       stat_rx_pkt_vlan,
    output wire logic       stat_rx_err_bad_fcs,
    output wire logic       stat_rx_err_oversize,
    output wire logic       stat_rx_err_bad_block,
    output wire logic       stat_rx_err_preamble
);

    logic crc_init;
    logic crc_update;
    logic crc_ok;

    rx_tap_if taps ();

    gmii_rx_pipe u_pipe (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .taps       (taps.pipe)
    );

    // crc runs on the first tap, ahead of the stream by four bytes
    fcs_check u_fcs (
        .clk        (clk),
        .data       (taps.rxd_d0),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .crc_ok     (crc_ok)
    );

    rx_frame_ctrl u_ctrl (
        .clk                   (clk),
        .reset_crc             (reset_crc),
        .taps                  (taps.ctrl),
        .crc_ok                (crc_ok),
        .crc_init              (crc_init),
        .crc_update            (crc_update),
        .cfg_rx_enable         (cfg_rx_enable),
        .cfg_rx_max_pkt_len    (cfg_rx_max_pkt_len),
        .rx_tdata              (rx_tdata),
        .rx_tvalid             (rx_tvalid),
        .rx_tlast              (rx_tlast),
        .rx_tuser              (rx_tuser),
        .stat_rx_pkt_len       (stat_rx_pkt_len),
        .stat_rx_pkt_good      (stat_rx_pkt_good),
        .stat_rx_pkt_bad       (stat_rx_pkt_bad),
        .stat_rx_pkt_ucast     (stat_rx_pkt_ucast),
        .stat_rx_pkt_mcast     (stat_rx_pkt_mcast),
        .stat_rx_pkt_bcast     (stat_rx_pkt_bcast),
        .stat_rx_pkt_vlan      (stat_rx_pkt_vlan),
        .stat_rx_err_bad_fcs   (stat_rx_err_bad_fcs),
        .stat_rx_err_oversize  (stat_rx_err_oversize),
        .stat_rx_err_bad_block (stat_rx_err_bad_block),
        .stat_rx_err_preamble  (stat_rx_err_preamble)
    );

endmodule

`default_nettype wire

// File: verif/tb_gmii_rx.sv
// testbench for the gmii receiver, random frames from a fixed seed checked against a model
`timescale 1ns/10ps
`default_nettype none

module tb_gmii_rx import eth_pkg::*; import rx_pkg::*; ();

    localparam int num_frames = 40;
    localparam int half_period = 20;
    // crc-32 polynomial, msb-first form
    localparam logic [31:0] crc_poly_msb = 32'h04C11DB7;

    typedef struct packed {
        // byte that should come out on the stream
        logic       fwd;
        logic       enable;
        frame_len_t max_len;
        logic       dv;
        logic       er;
        gmii_byte_t data;
    } stim_t;

    typedef struct packed {
        frame_len_t len;
        logic       tuser;
        logic       good;
        logic       bad;
        logic       ucast;
        logic       mcast;
        logic       bcast;
        logic       vlan;
        logic       bad_fcs;
        logic       oversize;
        logic       bad_block;
        logic       preamble;
    } status_t;

    logic       clk;
    logic       reset_crc;
    gmii_byte_t gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic       cfg_rx_enable;
    frame_len_t cfg_rx_max_pkt_len;
    gmii_byte_t rx_tdata;
    logic       rx_tvalid;
    logic       rx_tlast;
    logic       rx_tuser;
    frame_len_t stat_rx_pkt_len;
    logic       stat_rx_pkt_good;
    logic       stat_rx_pkt_bad;
    logic       stat_rx_pkt_ucast;
    logic       stat_rx_pkt_mcast;
    logic       stat_rx_pkt_bcast;
    logic       stat_rx_pkt_vlan;
    logic       stat_rx_err_bad_fcs;
    logic       stat_rx_err_oversize;
    logic       stat_rx_err_bad_block;
    logic       stat_rx_err_preamble;

    stim_t       stim_q[$];
    logic [8:0]  exp_byte_q[$];
    time         due_q[$];
    status_t     exp_status_q[$];
    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors;
    int          frames_expected;
    int          frames_seen;
    int          cycle_count;
    int          cycle_limit;

    gmii_rx_top DUT (.*);

    always #half_period clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(11)) % (hi - lo + 1);
    endfunction

    // msb-first register over lsb-first data, reflected and inverted at the end
    function automatic logic [31:0] reference_fcs(input gmii_byte_t bytes[$]);
        logic [31:0] r;
        logic [31:0] c;
        logic        fb;
        r = '1;
        foreach (bytes[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[31] ^ bytes[k][b];
                r = r << 1;
                if (fb) begin
                    r = r ^ crc_poly_msb;
                end
            end
        end
        for (int i = 0; i < 32; i++) begin
            c[i] = r[31-i];
        end
        return ~c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL at %0t: %s expected %0h got %0h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_status(input status_t st);
        check_value("rx_tvalid", 1'b1, rx_tvalid);
        check_value("rx_tlast", 1'b1, rx_tlast);
        check_value("rx_tuser", st.tuser, rx_tuser);
        check_value("stat_rx_pkt_len", st.len, stat_rx_pkt_len);
        check_value("stat_rx_pkt_good", st.good, stat_rx_pkt_good);
        check_value("stat_rx_pkt_bad", st.bad, stat_rx_pkt_bad);
        check_value("stat_rx_pkt_ucast", st.ucast, stat_rx_pkt_ucast);
        check_value("stat_rx_pkt_mcast", st.mcast, stat_rx_pkt_mcast);
        check_value("stat_rx_pkt_bcast", st.bcast, stat_rx_pkt_bcast);
        check_value("stat_rx_pkt_vlan", st.vlan, stat_rx_pkt_vlan);
        check_value("stat_rx_err_bad_fcs", st.bad_fcs, stat_rx_err_bad_fcs);
        check_value("stat_rx_err_oversize", st.oversize, stat_rx_err_oversize);
        check_value("stat_rx_err_bad_block", st.bad_block, stat_rx_err_bad_block);
        check_value("stat_rx_err_preamble", st.preamble, stat_rx_err_preamble);
    endtask

    task automatic push_idle(input int n, input logic en, input frame_len_t max_len);
        stim_t s;
        s = '0;
        s.enable = en;
        s.max_len = max_len;
        for (int i = 0; i < n; i++) begin
            stim_q.push_back(s);
        end
    endtask

    // mode 0..2 clean, 3 bad fcs, 4 oversize, 5 rx error, 6 preamble fault, 7 disabled
    task automatic build_frame(input int idx);
        gmii_byte_t  payload[$];
        gmii_byte_t  dst0;
        gmii_byte_t  xor_val;
        logic [31:0] fcs;
        logic [1:0]  dest_class;
        logic        en;
        logic        bcast_hdr;
        frame_len_t  max_len;
        int          mode;
        int          plen;
        int          err_pos;
        int          pre_pos;
        int          flip_pos;
        status_t     st;
        stim_t       s;
        mode = (idx < 8) ? idx : int'(rand_bits(3));
        plen = rand_range(60, 1530);
        dest_class = 2'(rand_bits(2));
        for (int i = 0; i < plen; i++) begin
            payload.push_back(gmii_byte_t'(rand_bits(8)));
        end
        case (dest_class)
            2'd1: begin
                payload[0] = payload[0] | 8'h01;
                payload[5] = payload[5] & 8'hFE;
            end
            2'd2: begin
                for (int i = 0; i < 6; i++) begin
                    payload[i] = eth_bcast_byte;
                end
            end
            default: payload[0] = payload[0] & 8'hFE;
        endcase
        if (rand_bits(1)) begin
            payload[12] = eth_vlan_tpid_hi;
            payload[13] = eth_vlan_tpid_lo;
        end else begin
            payload[12] = 8'h08;
        end
        fcs = reference_fcs(payload);
        if (mode == 3) begin
            flip_pos = rand_range(0, plen - 1);
            payload[flip_pos] = payload[flip_pos] ^ (8'h01 << rand_bits(3));
        end
        en = (mode != 7);
        max_len = (mode == 4) ? frame_len_t'(plen + 3 - rand_range(0, 31)) : default_max_len;
        err_pos = (mode == 5) ? rand_range(0, plen - 1) : -1;
        pre_pos = (mode == 6) ? rand_range(0, 6) : -1;
        xor_val = gmii_byte_t'(rand_bits(8));
        // zero or a change into the sfd would not be a preamble fault
        if (xor_val == 8'h00 || xor_val == 8'h80) begin
            xor_val = 8'h01;
        end
        s = '0;
        s.enable = en;
        s.max_len = max_len;
        s.dv = 1'b1;
        for (int i = 0; i < 7; i++) begin
            s.data = (i == pre_pos) ? (eth_preamble ^ xor_val) : eth_preamble;
            stim_q.push_back(s);
        end
        s.data = eth_sfd;
        stim_q.push_back(s);
        s.fwd = en;
        for (int i = 0; i < plen; i++) begin
            s.data = payload[i];
            s.er = (i == err_pos);
            stim_q.push_back(s);
        end
        s.er = 1'b0;
        s.fwd = 1'b0;
        for (int i = 0; i < 4; i++) begin
            s.data = fcs[8*i +: 8];
            stim_q.push_back(s);
        end
        push_idle(rand_range(12, 20), en, max_len);
        if (en) begin
            for (int i = 0; i < plen; i++) begin
                exp_byte_q.push_back({i == plen - 1, payload[i]});
            end
            dst0 = payload[0];
            bcast_hdr = 1'b1;
            for (int i = 0; i < 6; i++) begin
                if (payload[i] != eth_bcast_byte) begin
                    bcast_hdr = 1'b0;
                end
            end
            st.len = frame_len_t'(plen + 4);
            st.bcast = bcast_hdr;
            st.mcast = dst0[0] && !bcast_hdr;
            st.ucast = !dst0[0];
            st.vlan = (payload[12] == eth_vlan_tpid_hi) && (payload[13] == eth_vlan_tpid_lo);
            st.bad_block = (mode == 5);
            st.bad_fcs = (mode == 3);
            st.oversize = (plen + 4) > int'(max_len);
            st.preamble = (mode == 6);
            st.tuser = st.bad_block || st.bad_fcs || st.oversize;
            st.bad = st.tuser;
            st.good = !st.tuser;
            exp_status_q.push_back(st);
            frames_expected++;
        end
    endtask

    // outputs are registered, so look at them half a cycle later
    always @(negedge clk) begin : output_monitor
        logic [8:0] exp_byte;
        status_t    exp_st;
        logic       end_seen;
        time        due;
        if (reset_crc === 1'b0) begin
            end_seen = (rx_tlast | rx_tuser | stat_rx_pkt_good | stat_rx_pkt_bad
                | stat_rx_pkt_ucast | stat_rx_pkt_mcast | stat_rx_pkt_bcast | stat_rx_pkt_vlan
                | stat_rx_err_bad_fcs | stat_rx_err_oversize | stat_rx_err_bad_block
                | stat_rx_err_preamble) !== 1'b0 || stat_rx_pkt_len !== '0;
            if (rx_tvalid !== 1'b0) begin
                assert (exp_byte_q.size() != 0) else begin
                    $display("output byte at %0t while no frame was expected", $time);
                    other_errors++;
                end
                if (exp_byte_q.size() != 0) begin
                    exp_byte = exp_byte_q.pop_front();
                    check_value("rx_tdata", exp_byte[7:0], rx_tdata);
                    check_value("rx_tlast", exp_byte[8], rx_tlast);
                    if (due_q.size() != 0) begin
                        due = due_q.pop_front();
                        assert ($time == due) else begin
                            $display("output byte at %0t, it was due at %0t", $time, due);
                            other_errors++;
                        end
                    end
                end
            end
            if (end_seen) begin
                frames_seen++;
                assert (exp_status_q.size() != 0) else begin
                    $display("frame end at %0t while no frame was expected", $time);
                    other_errors++;
                end
                if (exp_status_q.size() != 0) begin
                    exp_st = exp_status_q.pop_front();
                    check_status(exp_st);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout, frames still pending after %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        stim_t s;
        clk = 1'b0;
        reset_crc = 1'b1;
        gmii_rxd = '0;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        cfg_rx_enable = 1'b1;
        cfg_rx_max_pkt_len = default_max_len;
        lfsr_state = 32'hde17b0d7;
        value_errors = 0;
        other_errors = 0;
        frames_expected = 0;
        frames_seen = 0;
        cycle_count = 0;
        cycle_limit = 0;
        push_idle(4, 1'b1, default_max_len);
        for (int f = 0; f < num_frames; f++) begin
            build_frame(f);
        end
        // twice the stimulus, reset and drain
        cycle_limit = 2 * (stim_q.size() + 10 + 20);
        repeat (10) @(posedge clk);
        reset_crc <= 1'b0;
        while (stim_q.size() != 0) begin
            s = stim_q.pop_front();
            @(posedge clk);
            gmii_rxd <= s.data;
            gmii_rx_dv <= s.dv;
            gmii_rx_er <= s.er;
            cfg_rx_enable <= s.enable;
            cfg_rx_max_pkt_len <= s.max_len;
            // delay line plus the stream register, seen at the falling edge
            if (s.fwd) begin
                due_q.push_back($time + (2 * pipe_depth + 3) * half_period);
            end
        end
        while (exp_byte_q.size() != 0 || exp_status_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        assert (frames_seen == frames_expected) else begin
            $display("%0d frames ended at the output, %0d were expected",
                frames_seen, frames_expected);
            other_errors++;
        end
        $display("summary: %0d frames, %0d value errors, %0d other errors",
            frames_expected, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/eth_pkg.sv
common/rx_pkg.sv
common/rx_tap_if.sv
hw/gmii_rx_pipe.sv
hw/fcs_check.sv
hw/rx_frame_ctrl/rx_frame_ctrl.sv
hw/gmii_rx_top.sv
verif/tb_gmii_rx.sv

// File: Bender.yml
package:
  name: gmii_rx

sources:
  - common/eth_pkg.sv
  - common/rx_pkg.sv
  - common/rx_tap_if.sv
  - hw/gmii_rx_pipe.sv
  - hw/fcs_check.sv
  - hw/rx_frame_ctrl/rx_frame_ctrl.sv
  - hw/gmii_rx_top.sv

  - target: test
    files:
      - verif/tb_gmii_rx.sv
